// File: source/calc_consts.svh
`ifndef CALC_CONSTS_SVH
`define CALC_CONSTS_SVH

// ========================================
// Screen geometry
// ========================================

// Text band, corners in pixels, bottom-right exclusive
`define CALC_TEXT_X0 100
`define CALC_TEXT_Y0 50
`define CALC_TEXT_X1 540
`define CALC_TEXT_Y1 110
`define CALC_CELL_W 40
`define CALC_TEXT_CHARS 11

// Button row, square buttons side by side
`define CALC_BTN_X0 70
`define CALC_BTN_Y0 200
`define CALC_BTN_SIZE 100
`define CALC_BTN_COUNT 5
`define CALC_BTN_BORDER 4

// ========================================
// Colours, 24-bit RGB
// ========================================
`define CALC_COL_BG 24'h002040
`define CALC_COL_TEXT_BG 24'hFFFFFF
`define CALC_COL_INK 24'h000000
`define CALC_COL_FLASH 24'h0000FF
`define CALC_COL_BORDER 24'h404040
`define CALC_COL_BTN 24'hC0C0C0
`define CALC_COL_BTN_SEL 24'h80A0FF

// ASCII codes the text line can hold
`define CALC_CHAR_SPACE 8'h20
`define CALC_CHAR_EQ 8'h3D
`define CALC_CHAR_MINUS 8'h2D
`define CALC_CHAR_ZERO 8'h30

`endif

// File: source/calc_pkg.sv
`default_nettype none

`include "calc_consts.svh"

package calc_pkg;

    // Operator codes, same order as the button row
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_DIV = 3'd3,
        OP_POW = 3'd4
    } op_code_e;

    // Calculator inputs as one bundle
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        op_code_e    op;
        logic        op_selected;
    } operands_t;

    // Where the current pixel falls on screen
    typedef struct packed {
        logic       in_text;
        logic       in_btn;
        logic [3:0] char_index;
        logic [4:0] char_x;
        logic [4:0] char_y;
        logic [2:0] btn_index;
        logic [6:0] btn_x;
        logic [6:0] btn_y;
        logic       btn_border;
    } screen_loc_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Slot 0 is the leftmost character
    typedef logic [0:`CALC_TEXT_CHARS-1][7:0] text_line_t;

endpackage

`default_nettype wire

// File: source/screen_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_consts.svh"

module screen_decode (
    input  logic [9:0]            pos_x,
    input  logic [9:0]            pos_y,
    output calc_pkg::screen_loc_t loc
);

    // Offsets from region corners, wrap outside the region
    logic [9:0] text_dx;
    logic [9:0] text_dy;
    logic [9:0] cell_q;
    logic [9:0] cell_r;
    logic [9:0] btn_dx;
    logic [9:0] btn_dy;
    logic [9:0] btn_q;
    logic [9:0] btn_r;

    always_comb begin
        text_dx = pos_x - 10'(`CALC_TEXT_X0);
        text_dy = pos_y - 10'(`CALC_TEXT_Y0);
        cell_q  = text_dx / 10'(`CALC_CELL_W);
        cell_r  = text_dx % 10'(`CALC_CELL_W);
        btn_dx  = pos_x - 10'(`CALC_BTN_X0);
        btn_dy  = pos_y - 10'(`CALC_BTN_Y0);
        btn_q   = btn_dx / 10'(`CALC_BTN_SIZE);
        btn_r   = btn_dx % 10'(`CALC_BTN_SIZE);

        // ========================================
        // Text band
        // ========================================
        loc.in_text = (pos_x >= 10'(`CALC_TEXT_X0)) && (pos_x < 10'(`CALC_TEXT_X1)) &&
                      (pos_y >= 10'(`CALC_TEXT_Y0)) && (pos_y < 10'(`CALC_TEXT_Y1));
        loc.char_index = cell_q[3:0];
        // Right margin of a cell (32..39) collapses onto column 31
        loc.char_x = (cell_r > 10'd31) ? 5'd31 : cell_r[4:0];
        // Rows are doubled, 60 lines fold to 30
        loc.char_y = text_dy[5:1];

        // ========================================
        // Button row
        // ========================================
        loc.in_btn = (pos_x >= 10'(`CALC_BTN_X0)) &&
                     (pos_x < 10'(`CALC_BTN_X0 + `CALC_BTN_SIZE * `CALC_BTN_COUNT)) &&
                     (pos_y >= 10'(`CALC_BTN_Y0)) &&
                     (pos_y < 10'(`CALC_BTN_Y0 + `CALC_BTN_SIZE));
        loc.btn_index = btn_q[2:0];
        loc.btn_x     = btn_r[6:0];
        loc.btn_y     = btn_dy[6:0];
        // Frame on all four sides
        loc.btn_border = (loc.btn_x < 7'(`CALC_BTN_BORDER)) ||
                         (loc.btn_x >= 7'(`CALC_BTN_SIZE - `CALC_BTN_BORDER)) ||
                         (loc.btn_y < 7'(`CALC_BTN_BORDER)) ||
                         (loc.btn_y >= 7'(`CALC_BTN_SIZE - `CALC_BTN_BORDER));
    end

endmodule

`default_nettype wire

// File: source/result_execute.sv
`timescale 1ns/10ps
`default_nettype none

module result_execute (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                show_result,
    input  calc_pkg::operands_t operands,
    input  logic [31:0]         result_value,
    output logic [31:0]         result_latched
);

    // A to the power of B[4:0], wraps at 32 bits
    function automatic logic [31:0] pow_calc(input logic [31:0] base, input logic [4:0] expo);
        logic [31:0] acc;
        acc = 32'd1;
        // Fixed trip count, unused steps leave acc alone
        for (int i = 0; i < 32; i++) begin
            if (i < int'(expo)) begin
                acc = acc * base;
            end
        end
        return acc;
    endfunction

    // Holds the shown result between show_result pulses
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_latched <= 32'd0;
        end else if (show_result) begin
            if (operands.op == calc_pkg::OP_POW) begin
                result_latched <= pow_calc(operands.a, operands.b[4:0]);
            end else begin
                result_latched <= result_value;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/expression_text.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_consts.svh"

module expression_text (
    input  calc_pkg::operands_t  operands,
    input  logic [31:0]          result_latched,
    input  logic                 show_result,
    output calc_pkg::text_line_t line,
    output logic                 result_negative
);

    // Lowest decimal digit of value as ASCII
    function automatic logic [7:0] dec_char(input logic [31:0] value);
        logic [31:0] digit;
        digit = value % 32'd10;
        return `CALC_CHAR_ZERO + digit[7:0];
    endfunction

    logic [31:0] result_abs;

    assign result_negative = result_latched[31];
    // Two's complement magnitude
    assign result_abs = result_negative ? (~result_latched + 32'd1) : result_latched;

    always_comb begin
        line = {`CALC_TEXT_CHARS{`CALC_CHAR_SPACE}};

        // A and B, two digits each, mod 100
        line[0] = dec_char(operands.a / 32'd10);
        line[1] = dec_char(operands.a);
        // Slot 2 stays blank, operator glyph drawn separately
        line[3] = dec_char(operands.b / 32'd10);
        line[4] = dec_char(operands.b);

        // "= R" only while the result is shown
        if (show_result) begin
            line[5]  = `CALC_CHAR_EQ;
            line[6]  = dec_char(result_abs / 32'd10000);
            line[7]  = dec_char(result_abs / 32'd1000);
            line[8]  = dec_char(result_abs / 32'd100);
            line[9]  = dec_char(result_abs / 32'd10);
            line[10] = dec_char(result_abs);
            // Sign takes the top digit
            if (result_negative) begin
                line[6] = `CALC_CHAR_MINUS;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/glyph_render.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_consts.svh"

module glyph_render (
    input  calc_pkg::screen_loc_t loc,
    input  calc_pkg::text_line_t  line,
    input  calc_pkg::op_code_e    op,
    output logic                  text_ink,
    output logic                  btn_ink,
    output logic [7:0]            cur_char
);

    // Operator shapes on a 16x16 coarse grid
    function automatic logic op_pixel(input calc_pkg::op_code_e code,
                                      input logic [3:0] gx, input logic [3:0] gy);
        int x;
        int y;
        logic hit;
        x = int'(gx);
        y = int'(gy);
        hit = 1'b0;
        case (code)
            calc_pkg::OP_ADD: hit = ((x >= 7) && (x <= 8) && (y >= 3) && (y <= 12)) ||
                                    ((y >= 7) && (y <= 8) && (x >= 3) && (x <= 12));
            calc_pkg::OP_SUB: hit = (y >= 7) && (y <= 8) && (x >= 3) && (x <= 12);
            // Two thick diagonals
            calc_pkg::OP_MUL: hit = (x >= 4) && (x <= 11) &&
                                    (((x - y >= -1) && (x - y <= 1)) ||
                                     ((x + y >= 14) && (x + y <= 16)));
            // Rising stroke, three cells thick
            calc_pkg::OP_DIV: hit = (x >= 3) && (x <= 13) && (x + y >= 15) && (x + y <= 17);
            calc_pkg::OP_POW: begin
                case (y)
                    4:       hit = (x >= 7) && (x <= 9);
                    5:       hit = (x == 7) || (x == 9);
                    6, 7:    hit = (x == 6) || (x == 10);
                    8, 9:    hit = (x == 5) || (x == 11);
                    10, 11:  hit = (x == 4) || (x == 12);
                    default: hit = 1'b0;
                endcase
            end
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    // 3x5 table at zx 2..4, zy 1..5, bit 0 top-left
    function automatic logic small_pixel(input logic [7:0] ch,
                                         input logic [2:0] zx, input logic [2:0] zy);
        logic [0:14] pat;
        case (ch)
            "1":              pat = 15'b010_110_010_010_111;
            "2":              pat = 15'b111_001_111_100_111;
            "3":              pat = 15'b111_001_111_001_111;
            "4":              pat = 15'b101_101_111_001_001;
            "5":              pat = 15'b111_100_111_001_111;
            "6":              pat = 15'b111_100_111_101_111;
            "7":              pat = 15'b111_001_001_001_001;
            "8":              pat = 15'b111_101_111_101_111;
            "9":              pat = 15'b111_101_111_001_111;
            `CALC_CHAR_MINUS: pat = 15'b000_000_111_000_000;
            `CALC_CHAR_EQ:    pat = 15'b000_111_000_111_000;
            default:          pat = 15'b0;
        endcase
        if ((zx < 3'd2) || (zx > 3'd4) || (zy < 3'd1) || (zy > 3'd5)) begin
            return 1'b0;
        end
        return pat[(int'(zy) - 1) * 3 + int'(zx) - 2];
    endfunction

    logic [2:0] zx;
    logic [2:0] zy;
    logic       ring;
    logic       cell_ink;

    // Current character, blank past the last slot
    assign cur_char = (loc.char_index < 4'(`CALC_TEXT_CHARS)) ? line[loc.char_index]
                                                               : `CALC_CHAR_SPACE;

    // 8x8 grid inside the cell
    assign zx = loc.char_x[4:2];
    assign zy = loc.char_y[4:2];

    // Zero as a hollow box
    assign ring = (((zy == 3'd1) || (zy == 3'd6)) && (zx >= 3'd2) && (zx <= 3'd5)) ||
                  (((zx == 3'd2) || (zx == 3'd5)) && (zy >= 3'd2) && (zy <= 3'd5));

    always_comb begin
        if (loc.char_index == 4'd2) begin
            cell_ink = op_pixel(op, loc.char_x[4:1], loc.char_y[4:1]);
        end else if (cur_char == `CALC_CHAR_ZERO) begin
            cell_ink = ring;
        end else begin
            cell_ink = small_pixel(cur_char, zx, zy);
        end
    end

    // Last column is the gap between cells
    assign text_ink = loc.in_text && (loc.char_x != 5'd31) && cell_ink;

    // Button glyph follows its position, not the selected op
    assign btn_ink = loc.in_btn && !loc.btn_border &&
                     op_pixel(calc_pkg::op_code_e'(loc.btn_index),
                              loc.btn_x[6:3], loc.btn_y[6:3]);

endmodule

`default_nettype wire

// File: source/pixel_color.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_consts.svh"

module pixel_color (
    input  logic                  video_on,
    input  logic                  op_highlight,
    input  calc_pkg::operands_t   operands,
    input  calc_pkg::screen_loc_t loc,
    input  logic                  text_ink,
    input  logic                  btn_ink,
    output calc_pkg::rgb_t        vga
);

    logic btn_selected;

    // Button under the pixel matches the chosen operator
    assign btn_selected = operands.op_selected && (loc.btn_index == operands.op);

    // ========================================
    // Colour priority
    // ========================================
    always_comb begin
        if (!video_on) begin
            vga = 24'h000000;
        end else if (loc.in_text) begin
            if (text_ink) begin
                // Operator slot flashes on a key press
                vga = ((loc.char_index == 4'd2) && op_highlight) ? `CALC_COL_FLASH
                                                                  : `CALC_COL_INK;
            end else begin
                vga = `CALC_COL_TEXT_BG;
            end
        end else if (loc.in_btn) begin
            if (loc.btn_border) begin
                vga = `CALC_COL_BORDER;
            end else begin
                vga = btn_selected ? `CALC_COL_BTN_SEL : `CALC_COL_BTN;
                // Glyph drawn over the fill
                if (btn_ink) begin
                    vga = `CALC_COL_INK;
                end
            end
        end else begin
            vga = `CALC_COL_BG;
        end
    end

endmodule

`default_nettype wire

// File: source/calc_display.sv
`timescale 1ns/10ps
`default_nettype none

module calc_display (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                video_on,
    input  logic [9:0]          pixel_x,
    input  logic [9:0]          pixel_y,
    input  calc_pkg::operands_t operands,
    input  logic                op_highlight,
    input  logic [31:0]         result_value,
    input  logic                show_result,
    output calc_pkg::rgb_t      vga
);

    calc_pkg::screen_loc_t loc;
    calc_pkg::text_line_t  line;
    logic [31:0]           result_latched;
    logic                  text_ink;
    logic                  btn_ink;

    // Pixel position to screen location
    screen_decode screen_decode_inst (
        .pos_x (pixel_x),
        .pos_y (pixel_y),
        .loc   (loc)
    );

    // Only clocked block, holds the shown result
    result_execute result_execute_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .show_result    (show_result),
        .operands       (operands),
        .result_value   (result_value),
        .result_latched (result_latched)
    );

    // Sign already sits in slot 6 of the line
    expression_text expression_text_inst (
        .operands        (operands),
        .result_latched  (result_latched),
        .show_result     (show_result),
        .line            (line),
        .result_negative ()
    );

    // Character code not needed past the glyph stage
    glyph_render glyph_render_inst (
        .loc      (loc),
        .line     (line),
        .op       (operands.op),
        .text_ink (text_ink),
        .btn_ink  (btn_ink),
        .cur_char ()
    );

    pixel_color pixel_color_inst (
        .video_on     (video_on),
        .op_highlight (op_highlight),
        .operands     (operands),
        .loc          (loc),
        .text_ink     (text_ink),
        .btn_ink      (btn_ink),
        .vga          (vga)
    );

endmodule

`default_nettype wire

// File: tests/calc_display_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module calc_display_asserts (
    input logic           clk,
    input logic           reset_n,
    input logic           show_result,
    input logic           video_on,
    input calc_pkg::rgb_t vga,
    input logic [31:0]    result_latched
);

    // Latch only loads on an edge with show_result high
    assert property (@(posedge clk) disable iff (!reset_n)
                     !show_result |=> $stable(result_latched))
        else $error("result_latched changed after a cycle with show_result low");

    // Blanking wins over every region
    assert property (@(posedge clk) !video_on |-> (vga == 24'h000000))
        else $error("vga not black while video_on is low");

    // Reset value seen in the first cycle out of reset
    assert property (@(posedge clk) $rose(reset_n) |-> (result_latched == 32'd0))
        else $error("result_latched not zero right after reset");

endmodule

bind calc_display calc_display_asserts calc_display_asserts_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .show_result    (show_result),
    .video_on       (video_on),
    .vga            (vga),
    .result_latched (result_latched)
);

`default_nettype wire

// File: tests/calc_display_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "calc_consts.svh"

module calc_display_tb;

    localparam int PERIOD = 4;
    localparam int RESET_CYCLES = 3;
    // Rough budget, one probe per cycle over all tests
    localparam int TEST_CYCLES = 160;
    localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES) * PERIOD + 200;

    localparam calc_pkg::rgb_t BLACK = 24'h000000;
    localparam calc_pkg::rgb_t COL_BG = `CALC_COL_BG;
    localparam calc_pkg::rgb_t COL_TEXT_BG = `CALC_COL_TEXT_BG;
    localparam calc_pkg::rgb_t COL_INK = `CALC_COL_INK;
    localparam calc_pkg::rgb_t COL_FLASH = `CALC_COL_FLASH;
    localparam calc_pkg::rgb_t COL_BORDER = `CALC_COL_BORDER;
    localparam calc_pkg::rgb_t COL_BTN = `CALC_COL_BTN;
    localparam calc_pkg::rgb_t COL_BTN_SEL = `CALC_COL_BTN_SEL;

    logic                clk;
    logic                reset_n;
    logic                video_on;
    logic [9:0]          pixel_x;
    logic [9:0]          pixel_y;
    calc_pkg::operands_t operands;
    logic                op_highlight;
    logic [31:0]         result_value;
    logic                show_result;
    calc_pkg::rgb_t      vga;
    logic [31:0]         rng_state;

    calc_display calc_display_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .video_on     (video_on),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .operands     (operands),
        .op_highlight (op_highlight),
        .result_value (result_value),
        .show_result  (show_result),
        .vga          (vga)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    // Pixel inside a text cell, zx/zy on the 8x8 grid
    function automatic logic [9:0] text_x(input int slot, input int zx);
        return 10'(`CALC_TEXT_X0 + `CALC_CELL_W * slot + 4 * zx + 1);
    endfunction

    function automatic logic [9:0] text_y(input int zy);
        return 10'(`CALC_TEXT_Y0 + 8 * zy + 2);
    endfunction

    function automatic logic [9:0] btn_x(input int index, input int offset);
        return 10'(`CALC_BTN_X0 + `CALC_BTN_SIZE * index + offset);
    endfunction

    // Coarse (7,7) lies on '+', '-' and 'x' only
    function automatic logic centre_has_ink(input calc_pkg::op_code_e code);
        case (code)
            calc_pkg::OP_ADD, calc_pkg::OP_SUB, calc_pkg::OP_MUL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Bit per slot that should show a zero ring
    function automatic logic [31:0] expected_ring_mask(input logic [31:0] a,
                                                       input logic [31:0] b,
                                                       input logic [31:0] r);
        logic [31:0] mag;
        logic [31:0] mask;
        mag = r[31] ? (32'd0 - r) : r;
        mask = 32'd0;
        // Operand digits, tens then units
        mask[0] = ((a / 32'd10) % 32'd10 == 32'd0);
        mask[1] = (a % 32'd10 == 32'd0);
        mask[3] = ((b / 32'd10) % 32'd10 == 32'd0);
        mask[4] = (b % 32'd10 == 32'd0);
        for (int slot = 10; slot >= 6; slot--) begin
            // Sign replaces the top digit
            if ((mag % 32'd10 == 32'd0) && !((slot == 6) && r[31])) begin
                mask[slot] = 1'b1;
            end
            mag = mag / 32'd10;
        end
        return mask;
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_rgb(input string name, input calc_pkg::rgb_t got,
                             input calc_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // New position on a rising edge, sample after settling
    task automatic move_to(input logic [9:0] x, input logic [9:0] y);
        @(posedge clk);
        pixel_x <= x;
        pixel_y <= y;
        #1;
    endtask

    task automatic check_pixel(input logic [9:0] x, input logic [9:0] y,
                               input calc_pkg::rgb_t exp);
        move_to(x, y);
        check_rgb($sformatf("vga(%0d,%0d)", x, y), vga, exp);
    endtask

    task automatic check_ink(input int slot, input int zx, input int zy, input logic ink);
        check_pixel(text_x(slot, zx), text_y(zy), ink ? COL_INK : COL_TEXT_BG);
    endtask

    // Non-ink text pixels must be text background
    task automatic read_ink(input int slot, input int zx, input int zy, output logic ink);
        move_to(text_x(slot, zx), text_y(zy));
        ink = (vga == COL_INK);
        if (!ink) begin
            check_rgb($sformatf("vga(slot %0d)", slot), vga, COL_TEXT_BG);
        end
    endtask

    // Ring: ink top middle, hollow centre, ink left side
    task automatic read_ring_mask(output logic [31:0] mask);
        logic top;
        logic mid;
        logic side;
        mask = 32'd0;
        // Every character slot, operator slot skipped
        for (int slot = 0; slot < `CALC_TEXT_CHARS; slot++) begin
            if (slot != 2) begin
                read_ink(slot, 3, 1, top);
                read_ink(slot, 3, 3, mid);
                read_ink(slot, 2, 3, side);
                mask[slot] = top && !mid && side;
            end
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic test_regions();
        logic [31:0] r;
        next_random(r);
        @(posedge clk);
        operands.a <= r;
        video_on <= 1'b0;
        check_pixel(10'd300, 10'd250, BLACK);
        @(posedge clk);
        video_on <= 1'b1;
        check_pixel(10'd10, 10'd10, COL_BG);
        check_pixel(10'd71, 10'd250, COL_BORDER);
        check_pixel(btn_x(1, 12), 10'd212, COL_BTN);
        @(posedge clk);
        operands.op <= calc_pkg::OP_MUL;
        operands.op_selected <= 1'b1;
        check_pixel(btn_x(2, 12), 10'd212, COL_BTN_SEL);
        check_pixel(btn_x(0, 12), 10'd212, COL_BTN);
    endtask

    task automatic test_button_glyphs();
        calc_pkg::op_code_e code;
        calc_pkg::rgb_t     fill;
        @(posedge clk);
        operands.op <= calc_pkg::OP_DIV;
        operands.op_selected <= 1'b1;
        for (int i = 0; i < `CALC_BTN_COUNT; i++) begin
            code = calc_pkg::op_code_e'(i);
            fill = (code == calc_pkg::OP_DIV) ? COL_BTN_SEL : COL_BTN;
            check_pixel(btn_x(i, 60), 10'd260, centre_has_ink(code) ? COL_INK : fill);
            check_pixel(btn_x(i, 12), 10'd212, fill);
        end
    endtask

    task automatic test_op_flash();
        @(posedge clk);
        operands.op <= calc_pkg::OP_ADD;
        op_highlight <= 1'b1;
        // Coarse (7,7) of slot 2 sits on both '+' bars
        check_pixel(10'd194, 10'd78, COL_FLASH);
        @(posedge clk);
        op_highlight <= 1'b0;
        check_pixel(10'd194, 10'd78, COL_INK);
    endtask

    task automatic test_negative_result();
        logic [31:0] r;
        logic [31:0] mask;
        next_random(r);
        @(posedge clk);
        operands.a <= r;
        operands.b <= {r[15:0], r[31:16]};
        operands.op <= calc_pkg::OP_SUB;
        result_value <= 32'hFFFF_FF9C;
        show_result <= 1'b1;
        check_ink(6, 3, 3, 1'b1);
        check_ink(6, 3, 1, 1'b0);
        // Nothing right of the 3-wide table
        check_ink(6, 5, 2, 1'b0);
        check_ink(9, 3, 1, 1'b1);
        check_ink(9, 3, 3, 1'b0);
        check_ink(10, 3, 1, 1'b1);
        check_ink(10, 3, 3, 1'b0);
        // '=' has no middle row
        check_ink(5, 3, 3, 1'b0);
        check_ink(5, 3, 2, 1'b1);
        read_ring_mask(mask);
        check_word("ring_mask", mask,
                   expected_ring_mask(r, {r[15:0], r[31:16]}, 32'hFFFF_FF9C));
    endtask

    task automatic test_local_power();
        logic [31:0] r;
        logic [31:0] mask;
        next_random(r);
        @(posedge clk);
        operands.a <= 32'd10;
        operands.b <= 32'd4;
        operands.op <= calc_pkg::OP_POW;
        result_value <= r;
        show_result <= 1'b1;
        read_ring_mask(mask);
        check_word("ring_mask", mask, expected_ring_mask(32'd10, 32'd4, 32'd10000));
        // Result slots blank out
        @(posedge clk);
        show_result <= 1'b0;
        for (int slot = 5; slot <= 10; slot++) begin
            check_ink(slot, 3, 1, 1'b0);
            check_ink(slot, 3, 3, 1'b0);
            check_ink(slot, 2, 3, 1'b0);
        end
        // New external value ignored for power
        next_random(r);
        @(posedge clk);
        result_value <= r;
        show_result <= 1'b1;
        read_ring_mask(mask);
        check_word("ring_mask", mask, expected_ring_mask(32'd10, 32'd4, 32'd10000));
    endtask

    // ========================================
    // Sequence and verdict
    // ========================================

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        video_on = 1'b1;
        pixel_x = '0;
        pixel_y = '0;
        operands = '0;
        op_highlight = 1'b0;
        result_value = '0;
        show_result = 1'b0;
        rng_state = 32'h5c8f;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        test_regions();
        test_button_glyphs();
        test_op_flash();
        test_negative_result();
        test_local_power();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/calc_pkg.sv
source/screen_decode.sv
source/result_execute.sv
source/expression_text.sv
source/glyph_render.sv
source/pixel_color.sv
source/calc_display.sv
tests/calc_display_asserts.sv
tests/calc_display_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = calc_display_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** FAILED ***
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG) || ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
